/* logic/img_pkg.sv */
package img_pkg;

    // ------------------------------
    // image geometry
    // ------------------------------
    localparam int IMG_W = 8;
    localparam int IMG_H = 8;
    localparam int IMG_C = 32;

    // total pixel count, channel-major raster
    localparam logic [11:0] IMG_PIX = 12'(IMG_W * IMG_H * IMG_C);

    // memory banking
    localparam int BANK_COUNT = 4;
    localparam int BANK_DEPTH = 512;

    typedef logic [7:0] pixel_t;
    typedef logic signed [13:0] out_word_t;
    typedef logic [$clog2(IMG_W)-1:0] coord_t;
    typedef logic [$clog2(IMG_C)-1:0] chan_t;

    // channel*64 + y*8 + x
    typedef logic [$clog2(IMG_W * IMG_H * IMG_C)-1:0] pix_addr_t;

    // 2x2 window must stay inside the 8x8 plane
    localparam coord_t ORG_MAX = 3'd6;

    // active channel depth
    typedef enum logic [1:0] {
        D8  = 2'd0,
        D16 = 2'd1,
        D32 = 2'd2
    } depth_e;

    typedef struct packed {
        coord_t origin_x;
        coord_t origin_y;
        depth_e depth;
    } view_t;

    // single write port
    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
        pixel_t    data;
    } mem_wr_t;

    // single read port, data one cycle later
    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
    } mem_rd_t;

endpackage

/* logic/op_pkg.sv */
package op_pkg;

    // ------------------------------
    // host opcodes
    // ------------------------------
    // codes 8..15 carry no function here and are treated as no-ops
    typedef enum logic [3:0] {
        LOAD    = 4'd0,
        ORG_R   = 4'd1,
        ORG_L   = 4'd2,
        ORG_U   = 4'd3,
        ORG_D   = 4'd4,
        SCALE_D = 4'd5,
        SCALE_U = 4'd6,
        DISPLAY = 4'd7
    } op_mode_e;

    // one-cycle command from sequencer to view registers
    typedef enum logic [2:0] {
        NONE   = 3'd0,
        RIGHT  = 3'd1,
        LEFT   = 3'd2,
        UP     = 3'd3,
        DOWN   = 3'd4,
        SHRINK = 3'd5,
        GROW   = 3'd6
    } view_cmd_e;

endpackage

/* logic/img_bank_mem.sv */
module img_bank_mem (
    input  logic             i_clk,
    input  img_pkg::mem_wr_t i_wr,
    input  img_pkg::mem_rd_t i_rd,
    output img_pkg::pixel_t  o_rd_data
);
    import img_pkg::*;

    localparam int BANK_BITS = $clog2(BANK_COUNT);
    localparam int OFF_BITS  = $clog2(BANK_DEPTH);
    localparam int XY_BITS   = $clog2(IMG_W * IMG_H);

    logic [BANK_BITS-1:0] wr_bank;
    logic [BANK_BITS-1:0] rd_bank;
    logic [BANK_BITS-1:0] rd_bank_q;
    logic [OFF_BITS-1:0]  wr_off;
    logic [OFF_BITS-1:0]  rd_off;
    pixel_t               bank_q [BANK_COUNT];

    // bank from channel low bits
    // offset from channel high bits plus the in-plane position
    assign wr_bank = i_wr.addr[XY_BITS +: BANK_BITS];
    assign wr_off  = {i_wr.addr[$bits(pix_addr_t)-1:XY_BITS+BANK_BITS], i_wr.addr[XY_BITS-1:0]};
    assign rd_bank = i_rd.addr[XY_BITS +: BANK_BITS];
    assign rd_off  = {i_rd.addr[$bits(pix_addr_t)-1:XY_BITS+BANK_BITS], i_rd.addr[XY_BITS-1:0]};

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        pixel_t mem [BANK_DEPTH];

        always_ff @(posedge i_clk) begin
            if (i_wr.valid && wr_bank == BANK_BITS'(b)) begin
                mem[wr_off] <= i_wr.data;
            end
            // registered read, only the addressed bank toggles
            if (i_rd.valid && rd_bank == BANK_BITS'(b)) begin
                bank_q[b] <= mem[rd_off];
            end
        end
    end

    // remember which bank answers next cycle
    always_ff @(posedge i_clk) begin
        if (i_rd.valid) begin
            rd_bank_q <= rd_bank;
        end
    end

    assign o_rd_data = bank_q[rd_bank_q];

endmodule

/* logic/load_engine.sv */
module load_engine (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic             i_in_valid,
    input  img_pkg::pixel_t  i_in_data,
    output logic             o_in_ready,
    output img_pkg::mem_wr_t o_wr,
    output logic             o_done
);
    import img_pkg::*;

    pix_addr_t pix_cnt;
    logic      in_ready;
    logic      accept;
    logic      last_pix;

    // a pixel counts only while the window is open
    assign accept   = i_in_valid & in_ready;
    assign last_pix = accept && (pix_cnt == pix_addr_t'(IMG_PIX - 12'd1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pix_cnt  <= '0;
            in_ready <= 1'b0;
        end else if (i_start) begin
            // fresh load always restarts at pixel 0
            pix_cnt  <= '0;
            in_ready <= 1'b1;
        end else if (accept) begin
            pix_cnt <= pix_cnt + 1'b1;
            if (last_pix) begin
                in_ready <= 1'b0;
            end
        end
    end

    // input order is already the raster address
    assign o_wr.valid = accept;
    assign o_wr.addr  = pix_cnt;
    assign o_wr.data  = i_in_data;

    assign o_in_ready = in_ready;
    assign o_done     = last_pix;

endmodule

/* logic/view_regs.sv */
module view_regs (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  op_pkg::view_cmd_e i_cmd,
    output img_pkg::view_t    o_view
);
    import img_pkg::*;
    import op_pkg::*;

    view_t view_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            view_q.origin_x <= '0;
            view_q.origin_y <= '0;
            view_q.depth    <= D32;
        end else begin
            case (i_cmd)
                // ------------------------------
                // origin moves, clamp at 0 and ORG_MAX
                // ------------------------------
                RIGHT: if (view_q.origin_x < ORG_MAX) view_q.origin_x <= view_q.origin_x + 1'b1;
                LEFT:  if (view_q.origin_x != '0) view_q.origin_x <= view_q.origin_x - 1'b1;
                // up means toward row 0
                UP:    if (view_q.origin_y != '0) view_q.origin_y <= view_q.origin_y - 1'b1;
                DOWN:  if (view_q.origin_y < ORG_MAX) view_q.origin_y <= view_q.origin_y + 1'b1;
                // ------------------------------
                // depth steps 32 -> 16 -> 8 and back
                // ------------------------------
                SHRINK: begin
                    case (view_q.depth)
                        D32:     view_q.depth <= D16;
                        D16:     view_q.depth <= D8;
                        default: view_q.depth <= D8;
                    endcase
                end
                GROW: begin
                    case (view_q.depth)
                        D8:      view_q.depth <= D16;
                        D16:     view_q.depth <= D32;
                        default: view_q.depth <= D32;
                    endcase
                end
                // idle cycles hold the view
                default: view_q <= view_q;
            endcase
        end
    end

    assign o_view = view_q;

endmodule

/* logic/display_streamer.sv */
module display_streamer (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  img_pkg::view_t      i_view,
    input  img_pkg::pixel_t     i_rd_data,
    output img_pkg::mem_rd_t    o_rd,
    output logic                o_out_valid,
    output img_pkg::out_word_t  o_out_data,
    output logic                o_done
);
    import img_pkg::*;

    logic       active;
    logic [1:0] win_pos;
    chan_t      chan;
    chan_t      chan_last;
    logic       rd_last;
    coord_t     rd_x;
    coord_t     rd_y;
    logic       out_valid_q;
    logic       out_last_q;

    // last channel index for the current depth
    always_comb begin
        case (i_view.depth)
            D8:      chan_last = chan_t'(7);
            D16:     chan_last = chan_t'(15);
            default: chan_last = chan_t'(IMG_C - 1);
        endcase
    end

    // ------------------------------
    // read side, one address per cycle
    // ------------------------------
    // win_pos bit 0 steps x, bit 1 steps y
    assign rd_x    = i_view.origin_x + coord_t'(win_pos[0]);
    assign rd_y    = i_view.origin_y + coord_t'(win_pos[1]);
    assign rd_last = active && (win_pos == 2'd3) && (chan == chan_last);

    assign o_rd.valid = active;
    assign o_rd.addr  = {chan, rd_y, rd_x};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active      <= 1'b0;
            win_pos     <= '0;
            chan        <= '0;
            out_valid_q <= 1'b0;
            out_last_q  <= 1'b0;
        end else begin
            // valid/last follow the read by one cycle, matching memory latency
            out_valid_q <= active;
            out_last_q  <= rd_last;
            if (i_start) begin
                active  <= 1'b1;
                win_pos <= '0;
                chan    <= '0;
            end else if (active) begin
                win_pos <= win_pos + 1'b1;
                // next channel after the fourth window pixel
                if (win_pos == 2'd3) begin
                    chan <= chan + 1'b1;
                end
                if (rd_last) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // ------------------------------
    // output side
    // ------------------------------
    assign o_out_valid = out_valid_q;
    assign o_out_data  = out_valid_q ? out_word_t'({6'd0, i_rd_data}) : '0;
    assign o_done      = out_valid_q & out_last_q;

endmodule

/* logic/op_sequencer.sv */
module op_sequencer (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_op_valid,
    input  op_pkg::op_mode_e  i_op_mode,
    input  logic              i_load_done,
    input  logic              i_disp_done,
    output logic              o_op_ready,
    output logic              o_load_start,
    output logic              o_disp_start,
    output op_pkg::view_cmd_e o_view_cmd
);
    import op_pkg::*;

    typedef enum logic [2:0] {
        S_STARTUP   = 3'd0,
        S_ANNOUNCE  = 3'd1,
        S_WAIT_OP   = 3'd2,
        S_BUSY_LOAD = 3'd3,
        S_BUSY_DISP = 3'd4
    } state_e;

    state_e    state;
    view_cmd_e cmd_dec;

    // opcode to view command, NONE for everything else
    always_comb begin
        case (i_op_mode)
            ORG_R:   cmd_dec = RIGHT;
            ORG_L:   cmd_dec = LEFT;
            ORG_U:   cmd_dec = UP;
            ORG_D:   cmd_dec = DOWN;
            SCALE_D: cmd_dec = SHRINK;
            SCALE_U: cmd_dec = GROW;
            default: cmd_dec = NONE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= S_STARTUP;
            o_op_ready   <= 1'b0;
            o_load_start <= 1'b0;
            o_disp_start <= 1'b0;
            o_view_cmd   <= NONE;
        end else begin
            // all outputs are single-cycle strobes
            o_op_ready   <= 1'b0;
            o_load_start <= 1'b0;
            o_disp_start <= 1'b0;
            o_view_cmd   <= NONE;
            case (state)
                S_STARTUP: state <= S_ANNOUNCE;
                // ready pulse, also closes view and unknown ops
                S_ANNOUNCE: begin
                    o_op_ready <= 1'b1;
                    state      <= S_WAIT_OP;
                end
                S_WAIT_OP: begin
                    if (i_op_valid) begin
                        if (i_op_mode == LOAD) begin
                            o_load_start <= 1'b1;
                            state        <= S_BUSY_LOAD;
                        end else if (i_op_mode == DISPLAY) begin
                            o_disp_start <= 1'b1;
                            state        <= S_BUSY_DISP;
                        end else begin
                            // view update lands while announcing
                            o_view_cmd <= cmd_dec;
                            state      <= S_ANNOUNCE;
                        end
                    end
                end
                S_BUSY_LOAD: begin
                    if (i_load_done) begin
                        o_op_ready <= 1'b1;
                        state      <= S_WAIT_OP;
                    end
                end
                S_BUSY_DISP: begin
                    if (i_disp_done) begin
                        o_op_ready <= 1'b1;
                        state      <= S_WAIT_OP;
                    end
                end
                default: state <= S_STARTUP;
            endcase
        end
    end

endmodule

/* logic/img_core.sv */
module img_core (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_op_valid,
    input  op_pkg::op_mode_e   i_op_mode,
    input  logic               i_in_valid,
    input  img_pkg::pixel_t    i_in_data,
    output logic               o_op_ready,
    output logic               o_in_ready,
    output logic               o_out_valid,
    output img_pkg::out_word_t o_out_data
);
    import img_pkg::*;
    import op_pkg::*;

    // ------------------------------
    // control strobes
    // ------------------------------
    logic      load_start;
    logic      load_done;
    logic      disp_start;
    logic      disp_done;
    view_cmd_e view_cmd;

    // datapath
    view_t   view;
    mem_wr_t mem_wr;
    mem_rd_t mem_rd;
    pixel_t  rd_data;

    op_sequencer op_sequencer_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_op_valid   (i_op_valid),
        .i_op_mode    (i_op_mode),
        .i_load_done  (load_done),
        .i_disp_done  (disp_done),
        .o_op_ready   (o_op_ready),
        .o_load_start (load_start),
        .o_disp_start (disp_start),
        .o_view_cmd   (view_cmd)
    );

    load_engine load_engine_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (load_start),
        .i_in_valid (i_in_valid),
        .i_in_data  (i_in_data),
        .o_in_ready (o_in_ready),
        .o_wr       (mem_wr),
        .o_done     (load_done)
    );

    view_regs view_regs_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (view_cmd),
        .o_view  (view)
    );

    // window reads go straight to the banks
    display_streamer display_streamer_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (disp_start),
        .i_view      (view),
        .i_rd_data   (rd_data),
        .o_rd        (mem_rd),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data),
        .o_done      (disp_done)
    );

    img_bank_mem img_bank_mem_i (
        .i_clk     (i_clk),
        .i_wr      (mem_wr),
        .i_rd      (mem_rd),
        .o_rd_data (rd_data)
    );

endmodule

/* verif/img_core_tb.sv */
module img_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import img_pkg::*;
    import op_pkg::*;

    // ------------------------------
    // run length and watchdog
    // ------------------------------
    localparam int CLK_PERIOD = 100;
    localparam logic [31:0] SEED = 32'h4bb7_1c34;
    // twice the pixel count covers one gap in four on the pixel stream
    localparam int LOAD_CYCLES = 2 * int'(IMG_PIX);
    localparam int N_DISPLAYS = 10;
    localparam int DISP_CYCLES = 4 * IMG_C + 6;
    // upper bound on origin, depth and unsupported ops
    localparam int N_OPS = 128;
    localparam int OP_CYCLES = 4;
    localparam longint WATCHDOG_NS = longint'(CLK_PERIOD) *
        (2 * (12 + LOAD_CYCLES + N_DISPLAYS * DISP_CYCLES + N_OPS * OP_CYCLES) + 1000);

    logic      i_clk;
    logic      i_rst_n;
    logic      i_op_valid;
    op_mode_e  i_op_mode;
    logic      i_in_valid;
    pixel_t    i_in_data;
    logic      o_op_ready;
    logic      o_in_ready;
    logic      o_out_valid;
    out_word_t o_out_data;

    // reference model
    pixel_t      ref_img [int'(IMG_PIX)];
    int          ref_ox;
    int          ref_oy;
    int          ref_depth;
    logic [31:0] rng_state;

    img_core img_core_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_mode   (i_op_mode),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .o_op_ready  (o_op_ready),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the DUT stopped answering");
        end_with_failure();
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // saturating origin and depth rules
    function automatic void apply_view_op(op_mode_e op);
        case (op)
            ORG_R:   if (ref_ox < int'(ORG_MAX)) ref_ox++;
            ORG_L:   if (ref_ox > 0) ref_ox--;
            // up is toward row 0
            ORG_U:   if (ref_oy > 0) ref_oy--;
            ORG_D:   if (ref_oy < int'(ORG_MAX)) ref_oy++;
            SCALE_D: if (ref_depth > 8) ref_depth = ref_depth / 2;
            SCALE_U: if (ref_depth < IMG_C) ref_depth = ref_depth * 2;
            default: ;
        endcase
    endfunction

    // ------------------------------
    // checks
    // ------------------------------
    task automatic end_with_failure();
        $display("TEST FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_problem(string why);
        $display("%s", why);
        end_with_failure();
    endtask

    task automatic compare_word(string name, out_word_t got, out_word_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns, %s = %0d, expected %0d", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns, %s = %0b, expected %0b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    // one-cycle op strobe with an optional stray pixel beside it
    task automatic issue_op(op_mode_e op, bit stray);
        logic [31:0] r;
        r = next_rand();
        // the previous ready pulse lasts one cycle only
        @(negedge i_clk);
        compare_flag("o_op_ready", o_op_ready, 1'b0);
        @(posedge i_clk);
        i_op_valid <= 1'b1;
        i_op_mode  <= op;
        i_in_valid <= stray;
        i_in_data  <= r[7:0];
        @(posedge i_clk);
        i_op_valid <= 1'b0;
        i_in_valid <= 1'b0;
    endtask

    task automatic check_reset();
        repeat (8) begin
            @(negedge i_clk);
            compare_flag("o_op_ready", o_op_ready, 1'b0);
            compare_flag("o_in_ready", o_in_ready, 1'b0);
            compare_flag("o_out_valid", o_out_valid, 1'b0);
            compare_word("o_out_data", o_out_data, '0);
        end
        @(posedge i_clk);
        i_rst_n <= 1'b1;
        // single announce on the second cycle after release
        repeat (2) begin
            @(negedge i_clk);
            compare_flag("o_op_ready", o_op_ready, 1'b0);
        end
        @(negedge i_clk);
        compare_flag("o_op_ready", o_op_ready, 1'b1);
    endtask

    task automatic run_view_op(op_mode_e op, bit stray);
        issue_op(op, stray);
        apply_view_op(op);
        @(negedge i_clk);
        compare_flag("o_out_valid", o_out_valid, 1'b0);
        compare_flag("o_in_ready", o_in_ready, 1'b0);
        compare_flag("o_op_ready", o_op_ready, 1'b0);
        @(negedge i_clk);
        compare_flag("o_out_valid", o_out_valid, 1'b0);
        compare_flag("o_in_ready", o_in_ready, 1'b0);
        compare_flag("o_op_ready", o_op_ready, 1'b1);
    endtask

    task automatic repeat_view_op(op_mode_e op, int n);
        repeat (n) run_view_op(op, 1'b0);
    endtask

    task automatic run_load();
        int          sent;
        logic [31:0] r;
        issue_op(LOAD, 1'b0);
        @(negedge i_clk);
        compare_flag("o_in_ready", o_in_ready, 1'b0);
        compare_flag("o_op_ready", o_op_ready, 1'b0);
        @(negedge i_clk);
        compare_flag("o_in_ready", o_in_ready, 1'b1);
        compare_flag("o_op_ready", o_op_ready, 1'b0);
        sent = 0;
        while (sent < int'(IMG_PIX)) begin
            @(posedge i_clk);
            r = next_rand();
            // random gaps on the input strobe
            i_in_valid <= (r[1:0] != 2'b00);
            i_in_data  <= r[15:8];
            if (r[1:0] != 2'b00) begin
                ref_img[sent] = r[15:8];
                sent++;
            end
            @(negedge i_clk);
            compare_flag("o_in_ready", o_in_ready, 1'b1);
            compare_flag("o_op_ready", o_op_ready, 1'b0);
        end
        @(posedge i_clk);
        i_in_valid <= 1'b0;
        @(negedge i_clk);
        compare_flag("o_in_ready", o_in_ready, 1'b0);
        compare_flag("o_op_ready", o_op_ready, 1'b1);
    endtask

    task automatic run_display();
        int        n_words;
        int        wait_cyc;
        int        idx;
        out_word_t exp;
        n_words = 4 * ref_depth;
        issue_op(DISPLAY, 1'b0);
        wait_cyc = 0;
        do begin
            @(negedge i_clk);
            wait_cyc++;
            compare_flag("o_op_ready", o_op_ready, 1'b0);
        end while (!o_out_valid && wait_cyc < 8);
        if (!o_out_valid) begin
            report_problem("DISPLAY produced no output word");
        end else if (wait_cyc != 3) begin
            report_problem($sformatf("first DISPLAY word after %0d cycles, expected 3", wait_cyc));
        end
        // four window corners per channel in channel order
        for (int i = 0; i < n_words; i++) begin
            if (i > 0) begin
                @(negedge i_clk);
            end
            idx = (i / 4) * IMG_W * IMG_H + (ref_oy + (i % 4) / 2) * IMG_W
                + ref_ox + (i % 2);
            exp = out_word_t'(ref_img[idx]);
            compare_flag("o_out_valid", o_out_valid, 1'b1);
            compare_word("o_out_data", o_out_data, exp);
            compare_flag("o_op_ready", o_op_ready, 1'b0);
        end
        @(negedge i_clk);
        if (o_out_valid) begin
            report_problem($sformatf("DISPLAY sent more than %0d words", n_words));
        end
        compare_flag("o_op_ready", o_op_ready, 1'b1);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        op_mode_e    dirs [4];
        logic [31:0] r;
        dirs = '{ORG_R, ORG_L, ORG_U, ORG_D};
        i_rst_n    = 1'b0;
        i_op_valid = 1'b0;
        i_op_mode  = LOAD;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        rng_state  = SEED;
        ref_ox     = 0;
        ref_oy     = 0;
        ref_depth  = IMG_C;

        check_reset();
        run_load();
        run_display();

        // origin walks forced past both edges first
        repeat_view_op(ORG_L, 2);
        repeat_view_op(ORG_U, 2);
        repeat_view_op(ORG_R, 8);
        repeat_view_op(ORG_D, 8);
        repeat (6) begin
            r = next_rand();
            repeat_view_op(dirs[r[1:0]], 1 + int'(r[4:2]));
        end
        run_display();

        // depth steps past 8 and 32
        repeat_view_op(SCALE_D, 3);
        run_display();
        repeat_view_op(SCALE_U, 1);
        run_display();
        repeat_view_op(SCALE_U, 3);
        run_display();
        repeat (4) begin
            r = next_rand();
            repeat_view_op(r[0] ? SCALE_U : SCALE_D, 1 + int'(r[2:1]));
            run_display();
        end

        // codes 8..15 with a stray pixel alongside
        for (int code = 8; code < 16; code++) begin
            run_view_op(op_mode_e'(code), 1'b1);
        end
        run_display();

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* project.f */
logic/img_pkg.sv
logic/op_pkg.sv
logic/img_bank_mem.sv
logic/load_engine.sv
logic/view_regs.sv
logic/display_streamer.sv
logic/op_sequencer.sv
logic/img_core.sv
verif/img_core_tb.sv

/* Bender.yml */
package:
  name: img_core

sources:
  - logic/img_pkg.sv
  - logic/op_pkg.sv
  - logic/img_bank_mem.sv
  - logic/load_engine.sv
  - logic/view_regs.sv
  - logic/display_streamer.sv
  - logic/op_sequencer.sv
  - logic/img_core.sv
  - target: test
    files:
      - verif/img_core_tb.sv
